//--- radio_regs_pkg.sv
// settings-bus address map, register structs and readback selects, imported by the slot control
`default_nettype none

package radio_regs_pkg;

   // --------------------------------------------------
   // block bases and channel stride
   // --------------------------------------------------
   localparam logic [7:0] sr_db_base_default    = 8'd160; // slot control block
   localparam logic [7:0] sr_rx_fe_base_default = 8'd224; // first rx front-end channel
   localparam logic [7:0] sr_fe_chan_offset     = 8'd16;  // one block per channel

   // offsets from the slot base
   // atr words sit at 0..3 in the same order as the atr state encoding
   localparam logic [7:0] sr_atr_idle = 8'd0;
   localparam logic [7:0] sr_atr_rx   = 8'd1;
   localparam logic [7:0] sr_atr_tx   = 8'd2;
   localparam logic [7:0] sr_atr_fdx  = 8'd3;
   localparam logic [7:0] sr_gpio_ddr = 8'd4; // 1 = pin driven
   localparam logic [7:0] sr_misc_out = 8'd5;

   // offsets inside each channel block
   localparam logic [7:0] sr_fe_iq_swap   = 8'd0; // bit 0 only
   localparam logic [7:0] sr_fe_dc_offset = 8'd1; // {dc_i, dc_q}

   // --------------------------------------------------
   // readback select
   // --------------------------------------------------
   typedef enum logic [1:0] {
      rb_gpio_misc = 2'd0, // {gpio_in, misc_in}
      rb_atr       = 2'd1, // {gpio_out, ddr}
      rb_fe        = 2'd2  // {dc ch1, dc ch0}
   } rb_sel_e;             // code 3 reads as zero

   // slot registers as seen by the atr controller
   typedef struct packed {
      logic [3:0][31:0] atr;      // gpio word per atr state, idle at index 0
      logic [31:0]      ddr;
      logic [31:0]      misc_out;
   } db_regs_t;

endpackage

`default_nettype wire

//--- radio_fe_pkg.sv
// sample, atr state and per-channel correction types shared by the receive path and atr control
`default_nettype none

package radio_fe_pkg;

   // --------------------------------------------------
   // sizing
   // --------------------------------------------------
   localparam int num_channels_default = 2; // two rx channels per slot

   // one adc word, i in the upper half like the radio bus
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_sample_t;

   // per-channel front-end correction
   typedef struct packed {
      logic               iq_swap; // exchange i and q before dc removal
      logic signed [15:0] dc_i;    // subtracted from i
      logic signed [15:0] dc_q;    // subtracted from q
   } fe_corr_t;

   // --------------------------------------------------
   // atr state
   // --------------------------------------------------
   // encoding is {run_tx, run_rx} so the state can be built straight from the run bits,
   // and it doubles as the index of the matching atr gpio word
   typedef enum logic [1:0] {
      atr_idle = 2'd0,
      atr_rx   = 2'd1,
      atr_tx   = 2'd2,
      atr_fdx  = 2'd3
   } atr_state_e;

endpackage

`default_nettype wire

//--- settings_regs.sv
// slot register file, decodes settings-bus writes into register structs and answers readback
`default_nettype none
`timescale 1ns/10ps

module settings_regs #(
   parameter logic [7:0] SR_DB_BASE    = radio_regs_pkg::sr_db_base_default,
   parameter logic [7:0] SR_RX_FE_BASE = radio_regs_pkg::sr_rx_fe_base_default,
   parameter int         NUM_CHANNELS  = radio_fe_pkg::num_channels_default
)(
   input  wire                                        radio_clk,
   input  wire                                        i_rst_n,
   // settings bus, one write per strobed edge
   input  wire                                        i_set_stb,
   input  wire [7:0]                                  i_set_addr,
   input  wire [31:0]                                 i_set_data,
   // readback
   input  wire                                        i_rb_stb,
   input  wire radio_regs_pkg::rb_sel_e               i_rb_addr,
   output logic                                       o_rb_stb,
   output logic [63:0]                                o_rb_data,
   // readback sources
   input  wire [31:0]                                 i_gpio_in,
   input  wire [31:0]                                 i_gpio_out,
   input  wire [31:0]                                 i_gpio_ddr,
   input  wire [31:0]                                 i_misc_in_q,
   // register outputs
   output radio_regs_pkg::db_regs_t                   o_db_regs,
   output radio_fe_pkg::fe_corr_t [NUM_CHANNELS-1:0]  o_fe_corr
);

   import radio_regs_pkg::*;

   // rb_fe only has room for two channels
   localparam int RB_FE_CHANS = (NUM_CHANNELS < 2) ? NUM_CHANNELS : 2;

   logic [7:0]  db_off;  // address relative to the slot block
   logic [7:0]  fe_off;  // address relative to the rx fe blocks
   logic [7:0]  fe_chan; // channel block hit
   logic [7:0]  fe_reg;  // register inside that block
   logic [63:0] rb_word; // unregistered readback mux

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------
   always_comb begin
      db_off  = i_set_addr - SR_DB_BASE;   // below base wraps high, never matches
      fe_off  = i_set_addr - SR_RX_FE_BASE;
      fe_chan = fe_off / sr_fe_chan_offset;
      fe_reg  = fe_off % sr_fe_chan_offset;
   end

   // writes land on the strobed edge, other addresses are dropped
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_db_regs <= '0;
         o_fe_corr <= '0;
      end else if (i_set_stb) begin
         if (db_off <= sr_atr_fdx) begin
            o_db_regs.atr[db_off[1:0]] <= i_set_data; // idle, rx, tx, fdx
         end
         if (db_off == sr_gpio_ddr) begin
            o_db_regs.ddr <= i_set_data;
         end
         if (db_off == sr_misc_out) begin
            o_db_regs.misc_out <= i_set_data;
         end
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (fe_chan == 8'(c) && fe_reg == sr_fe_iq_swap) begin
               o_fe_corr[c].iq_swap <= i_set_data[0];
            end
            if (fe_chan == 8'(c) && fe_reg == sr_fe_dc_offset) begin
               o_fe_corr[c].dc_i <= i_set_data[31:16];
               o_fe_corr[c].dc_q <= i_set_data[15:0];
            end
         end
      end
   end

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   always_comb begin
      rb_word = '0;
      case (i_rb_addr)
         rb_gpio_misc: rb_word = {i_gpio_in, i_misc_in_q};
         rb_atr:       rb_word = {i_gpio_out, i_gpio_ddr};
         rb_fe: begin
            for (int c = 0; c < RB_FE_CHANS; c++) begin
               rb_word[c*32 +: 32] = {o_fe_corr[c].dc_i, o_fe_corr[c].dc_q}; // ch0 low
            end
         end
         default:      rb_word = '0; // unused code
      endcase
   end

   // answer one cycle after the request
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         if (i_rb_stb) begin
            o_rb_data <= rb_word; // held until the next request
         end
      end
   end

   // a strobed write with a floating address would corrupt an unknown register
   a_set_addr_known : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_set_stb |-> !$isunknown(i_set_addr))
      else $error("settings write with unknown address");

endmodule

`default_nettype wire

//--- db_atr_control.sv
// atr state tracking for one slot, drives daughterboard gpio, radio leds and misc output registers
`default_nettype none
`timescale 1ns/10ps

module db_atr_control (
   input  wire                             radio_clk,
   input  wire                             i_rst_n,
   // registers from the settings bus
   input  wire radio_regs_pkg::db_regs_t   i_db_regs,
   // run levels, already ORed over the channels
   input  wire                             i_rx_run,
   input  wire                             i_tx_run,
   // misc
   input  wire [31:0]                      i_misc_in,
   output logic [31:0]                     o_misc_in_q,
   output logic [31:0]                     o_misc_out,
   // gpio and leds
   output logic [31:0]                     o_db_gpio_out,
   output logic [31:0]                     o_db_gpio_ddr,
   output logic [2:0]                      o_led            // {rx, txrx_tx, txrx_rx}
);

   import radio_fe_pkg::*;

   atr_state_e atr_state; // one cycle behind the run levels
   logic       st_rx;     // receiving in this state
   logic       st_tx;     // transmitting in this state

   // --------------------------------------------------
   // atr state
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         atr_state <= atr_idle;
      end else begin
         atr_state <= atr_state_e'({i_tx_run, i_rx_run}); // encoding is {tx, rx}
      end
   end

   always_comb begin
      st_rx = (atr_state == atr_rx) || (atr_state == atr_fdx);
      st_tx = (atr_state == atr_tx) || (atr_state == atr_fdx);
   end

   // --------------------------------------------------
   // output registers
   // --------------------------------------------------
   // second stage, so writes and run changes both reach the pins two cycles later
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_led         <= '0;
         o_misc_out    <= '0;
      end else begin
         o_db_gpio_out <= i_db_regs.atr[atr_state]; // word of the current state
         o_db_gpio_ddr <= i_db_regs.ddr;
         o_led         <= {st_rx, st_tx, st_rx & ~st_tx}; // txrx port only rx when not tx
         o_misc_out    <= i_db_regs.misc_out;
      end
   end

   // board pins sampled once before readback
   always_ff @(posedge radio_clk) begin
      o_misc_in_q <= i_misc_in;
   end

   // the txrx antenna port cannot be lit for rx and tx at once
   a_led_txrx_excl : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      !(o_led[0] && o_led[1]))
      else $error("txrx led shows rx and tx together");

endmodule

`default_nettype wire

//--- rx_frontend.sv
// per-channel receive pipeline, iq swap then saturating dc offset removal, two cycles latency
`default_nettype none
`timescale 1ns/10ps

module rx_frontend #(
   parameter int NUM_CHANNELS = radio_fe_pkg::num_channels_default
)(
   input  wire                                          radio_clk,
   input  wire                                          i_rst_n,
   input  wire radio_fe_pkg::iq_sample_t                i_rx,      // shared adc word
   input  wire [NUM_CHANNELS-1:0]                       i_rx_run,
   input  wire radio_fe_pkg::fe_corr_t [NUM_CHANNELS-1:0] i_fe_corr,
   output radio_fe_pkg::iq_sample_t [NUM_CHANNELS-1:0]  o_rx_data,
   output logic [NUM_CHANNELS-1:0]                      o_rx_stb
);

   import radio_fe_pkg::*;

   // a - b clipped to 16 bits
   function automatic logic signed [15:0] sat_sub(input logic signed [15:0] a,
                                                  input logic signed [15:0] b);
      logic signed [16:0] diff;
      diff = {a[15], a} - {b[15], b};
      if (diff[16] != diff[15]) begin
         return diff[16] ? 16'sh8000 : 16'sh7fff; // pinned to the rail it crossed
      end
      return diff[15:0];
   endfunction

   genvar c;
   generate
      for (c = 0; c < NUM_CHANNELS; c++) begin : g_chan
         iq_sample_t s1_data; // after swap
         logic       s1_vld;
         logic       s2_vld;

         // --------------------------------------------------
         // valid pipe
         // --------------------------------------------------
         always_ff @(posedge radio_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
               s1_vld <= 1'b0;
               s2_vld <= 1'b0;
            end else begin
               s1_vld <= i_rx_run[c]; // one sample per cycle while running
               s2_vld <= s1_vld;
            end
         end

         // stage 1, optional i/q exchange
         always_ff @(posedge radio_clk) begin
            if (i_rx_run[c]) begin
               s1_data <= i_fe_corr[c].iq_swap ? {i_rx.q, i_rx.i} : i_rx;
            end
         end

         // stage 2, dc removal on the already swapped sample
         always_ff @(posedge radio_clk) begin
            if (s1_vld) begin
               o_rx_data[c].i <= sat_sub(s1_data.i, i_fe_corr[c].dc_i);
               o_rx_data[c].q <= sat_sub(s1_data.q, i_fe_corr[c].dc_q);
            end
         end

         assign o_rx_stb[c] = s2_vld;

         // every strobe must trace back to a running input two cycles earlier
         a_stb_from_run : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
            o_rx_stb[c] |-> $past(i_rx_run[c], 2))
            else $error("rx strobe on channel %0d without run", c);
      end
   endgenerate

endmodule

`default_nettype wire

//--- radio_core_top.sv
// daughterboard slice top, connects the register file, atr control and rx front end of one slot
`default_nettype none
`timescale 1ns/10ps

module radio_core_top #(
   parameter logic [7:0] SR_DB_BASE    = radio_regs_pkg::sr_db_base_default,
   parameter logic [7:0] SR_RX_FE_BASE = radio_regs_pkg::sr_rx_fe_base_default,
   parameter int         NUM_CHANNELS  = radio_fe_pkg::num_channels_default
)(
   input  wire                                         radio_clk,
   input  wire                                         i_rst_n,
   // settings bus
   input  wire                                         i_set_stb,
   input  wire [7:0]                                   i_set_addr,
   input  wire [31:0]                                  i_set_data,
   // readback
   input  wire                                         i_rb_stb,
   input  wire radio_regs_pkg::rb_sel_e                i_rb_addr,
   output wire                                         o_rb_stb,
   output wire [63:0]                                  o_rb_data,
   // run levels per channel
   input  wire [NUM_CHANNELS-1:0]                      i_rx_run,
   input  wire [NUM_CHANNELS-1:0]                      i_tx_run,
   // adc and rx stream
   input  wire radio_fe_pkg::iq_sample_t               i_rx,
   output wire radio_fe_pkg::iq_sample_t [NUM_CHANNELS-1:0] o_rx_data,
   output wire [NUM_CHANNELS-1:0]                      o_rx_stb,
   // daughterboard pins
   input  wire [31:0]                                  i_db_gpio_in,
   output wire [31:0]                                  o_db_gpio_out,
   output wire [31:0]                                  o_db_gpio_ddr,
   output wire [2:0]                                   o_led,
   input  wire [31:0]                                  i_misc_in,
   output wire [31:0]                                  o_misc_out
);

   import radio_regs_pkg::*;
   import radio_fe_pkg::*;

   db_regs_t                    db_regs;   // slot registers
   fe_corr_t [NUM_CHANNELS-1:0] fe_corr;   // per-channel correction
   logic [31:0]                 misc_in_q; // sampled pins for readback

   // --------------------------------------------------
   // register file
   // --------------------------------------------------
   settings_regs #(
      .SR_DB_BASE   (SR_DB_BASE),
      .SR_RX_FE_BASE(SR_RX_FE_BASE),
      .NUM_CHANNELS (NUM_CHANNELS)
   ) u_settings_regs (
      .radio_clk  (radio_clk),     .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),     .i_set_addr (i_set_addr),   .i_set_data(i_set_data),
      .i_rb_stb   (i_rb_stb),      .i_rb_addr  (i_rb_addr),
      .o_rb_stb   (o_rb_stb),      .o_rb_data  (o_rb_data),
      .i_gpio_in  (i_db_gpio_in),  .i_gpio_out (o_db_gpio_out),
      .i_gpio_ddr (o_db_gpio_ddr), .i_misc_in_q(misc_in_q),
      .o_db_regs  (db_regs),       .o_fe_corr  (fe_corr)
   );

   // one atr per slot, so any running channel counts for the whole board
   db_atr_control u_db_atr_control (
      .radio_clk    (radio_clk),     .i_rst_n      (i_rst_n),
      .i_db_regs    (db_regs),
      .i_rx_run     (|i_rx_run),     .i_tx_run     (|i_tx_run),
      .i_misc_in    (i_misc_in),     .o_misc_in_q  (misc_in_q),
      .o_misc_out   (o_misc_out),
      .o_db_gpio_out(o_db_gpio_out), .o_db_gpio_ddr(o_db_gpio_ddr),
      .o_led        (o_led)
   );

   // every channel sees the same adc word
   rx_frontend #(
      .NUM_CHANNELS(NUM_CHANNELS)
   ) u_rx_frontend (
      .radio_clk(radio_clk), .i_rst_n  (i_rst_n),
      .i_rx     (i_rx),      .i_rx_run (i_rx_run), .i_fe_corr(fe_corr),
      .o_rx_data(o_rx_data), .o_rx_stb (o_rx_stb)
   );

endmodule

`default_nettype wire

//--- tb_radio_core.sv
// directed testbench for the radio slot top, run as the simulation top from verilog.f
`default_nettype none
`timescale 1ns/10ps

module tb_radio_core;

   import radio_regs_pkg::*;
   import radio_fe_pkg::*;

   localparam int NCH        = 2;
   localparam int EST_CYCLES = 500;            // rough length of all tests together
   localparam int MAX_CYCLES = 4 * EST_CYCLES; // hard stop

   logic                   radio_clk;
   logic                   rst_n;
   logic                   set_stb;
   logic [7:0]             set_addr;
   logic [31:0]            set_data;
   logic                   rb_stb;
   rb_sel_e                rb_addr;
   wire                    rb_stb_o;
   wire  [63:0]            rb_data;
   logic [NCH-1:0]         rx_run;
   logic [NCH-1:0]         tx_run;
   iq_sample_t             rx;
   iq_sample_t [NCH-1:0]   rx_data;
   wire  [NCH-1:0]         rx_stb;
   logic [31:0]            gpio_in;
   wire  [31:0]            gpio_out;
   wire  [31:0]            gpio_ddr;
   wire  [2:0]             led;
   logic [31:0]            misc_in;
   wire  [31:0]            misc_out;

   integer            seed;
   int                cycle_cnt = 0;
   int                errors = 0;
   logic [31:0]       atr_w [4];          // expected atr words with idle first
   logic [31:0]       ddr_w;
   logic              swap_c [NCH];       // expected correction per channel
   logic signed [15:0] dci_c [NCH];
   logic signed [15:0] dcq_c [NCH];
   logic [31:0]       hist_smp [4];       // inputs of the last cycles indexed by cycle mod 4
   logic [NCH-1:0]    hist_run [4];
   int                stb_cnt [NCH];

   radio_core_top #(
      .SR_DB_BASE   (sr_db_base_default),
      .SR_RX_FE_BASE(sr_rx_fe_base_default),
      .NUM_CHANNELS (NCH)
   ) i_dut (
      .radio_clk(radio_clk), .i_rst_n(rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rb_stb(rb_stb), .i_rb_addr(rb_addr), .o_rb_stb(rb_stb_o), .o_rb_data(rb_data),
      .i_rx_run(rx_run), .i_tx_run(tx_run),
      .i_rx(rx), .o_rx_data(rx_data), .o_rx_stb(rx_stb),
      .i_db_gpio_in(gpio_in), .o_db_gpio_out(gpio_out), .o_db_gpio_ddr(gpio_ddr),
      .o_led(led), .i_misc_in(misc_in), .o_misc_out(misc_out)
   );

   // --------------------------------------------------
   // clock and cycle limit
   // --------------------------------------------------
   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk; // 4 ns period
   end

   always @(posedge radio_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("tests failed");
         $fatal(1, "stopped by cycle limit");
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      assert (got === exp) else begin
         errors++;
         $display("ERR @%0t ns: %s got %0h expected %0h", $time, what, got, exp);
         $display("tests failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   // one strobed write that returns on the falling edge after the sampling edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge radio_clk);
      set_stb  = 1'b0;
   endtask

   task automatic read_reg(input rb_sel_e sel, output logic [63:0] data);
      rb_stb  = 1'b1;
      rb_addr = sel;
      @(negedge radio_clk);
      check_eq(rb_stb_o, 1, "readback strobe one cycle after request");
      data   = rb_data;
      rb_stb = 1'b0;
      @(negedge radio_clk);
      check_eq(rb_stb_o, 0, "readback strobe single pulse");
   endtask

   function automatic logic [2:0] led_of(input logic st_rx, input logic st_tx);
      return {st_rx, st_tx, st_rx & ~st_tx};
   endfunction

   // clamp to the 16 bit range
   function automatic logic [15:0] clip16(input int v);
      if (v > 32767) begin
         return 16'h7fff;
      end
      if (v < -32768) begin
         return 16'h8000;
      end
      return v[15:0];
   endfunction

   // swap first, then remove dc
   function automatic logic [31:0] expect_rx(input logic [31:0] s, input int c);
      int a;
      int b;
      a = swap_c[c] ? int'($signed(s[15:0]))  : int'($signed(s[31:16]));
      b = swap_c[c] ? int'($signed(s[31:16])) : int'($signed(s[15:0]));
      return {clip16(a - int'(dci_c[c])), clip16(b - int'(dcq_c[c]))};
   endfunction

   // outputs now belong to the inputs driven two cycles ago
   task automatic check_rx_outputs();
      int idx;
      idx = (cycle_cnt - 2) & 3;
      for (int c = 0; c < NCH; c++) begin
         check_eq(rx_stb[c], hist_run[idx][c], $sformatf("rx strobe ch%0d", c));
         if (rx_stb[c]) begin
            stb_cnt[c]++;
         end
         if (hist_run[idx][c]) begin
            check_eq(rx_data[c], expect_rx(hist_smp[idx], c), $sformatf("rx data ch%0d", c));
         end
      end
   endtask

   // one sample per cycle with the first two pinned to the rails
   task automatic stream_samples(input int n, input logic [NCH-1:0] run);
      logic [31:0] smp;
      rx_run = '0;
      repeat (3) @(negedge radio_clk); // drain the pipe
      for (int k = 0; k < 4; k++) begin
         hist_run[k] = '0;
      end
      stb_cnt = '{default: 0};
      for (int k = 0; k < n + 3; k++) begin
         check_rx_outputs();
         smp = $random(seed);
         if (k == 0) smp = {16'h8000, 16'h7fff};
         if (k == 1) smp = {16'h7fff, 16'h8000};
         rx     = smp;
         rx_run = (k < n) ? run : '0;
         hist_smp[cycle_cnt & 3] = smp;
         hist_run[cycle_cnt & 3] = rx_run;
         @(negedge radio_clk);
      end
   endtask

   function automatic logic in_blocks(input logic [7:0] a);
      logic [7:0] ch1;
      ch1 = sr_rx_fe_base_default + sr_fe_chan_offset;
      return (a >= sr_db_base_default && a <= sr_db_base_default + sr_misc_out) ||
             a == sr_rx_fe_base_default || a == sr_rx_fe_base_default + 8'd1 ||
             a == ch1 || a == ch1 + 8'd1;
   endfunction

   // --------------------------------------------------
   // tests
   // --------------------------------------------------
   task automatic test_reset_values();
      check_eq(rx_stb, 0, "rx strobe after reset");
      check_eq(rb_stb_o, 0, "readback strobe after reset");
      check_eq(led, 0, "leds after reset");
      check_eq(gpio_out, 0, "gpio out after reset");
      check_eq(gpio_ddr, 0, "gpio ddr after reset");
      check_eq(misc_out, 0, "misc out after reset");
   endtask

   task automatic test_atr_switching();
      logic [1:0]  st;
      logic [1:0]  prev_st;
      logic [63:0] rd;
      for (int s = 0; s < 4; s++) begin
         atr_w[s] = $random(seed);
         write_reg(sr_db_base_default + 8'(s), atr_w[s]);
      end
      ddr_w = $random(seed);
      write_reg(sr_db_base_default + sr_gpio_ddr, ddr_w);
      @(negedge radio_clk);
      check_eq(gpio_ddr, ddr_w, "gpio ddr");
      check_eq(gpio_out, atr_w[0], "idle gpio word");
      prev_st = 2'd0;
      for (int k = 0; k < 16; k++) begin
         rx_run = k[1:0];
         tx_run = k[3:2];
         st = {|k[3:2], |k[1:0]}; // {tx, rx}
         @(negedge radio_clk);
         check_eq(gpio_out, atr_w[prev_st], "gpio out one cycle after run change");
         check_eq(led, led_of(prev_st[0], prev_st[1]), "leds one cycle after run change");
         @(negedge radio_clk);
         check_eq(gpio_out, atr_w[st], "gpio out two cycles after run change");
         check_eq(led, led_of(st[0], st[1]), "leds two cycles after run change");
         prev_st = st;
      end
      read_reg(rb_atr, rd);
      check_eq(rd, {atr_w[prev_st], ddr_w}, "atr readback");
      rx_run = '0;
      tx_run = '0;
      repeat (3) @(negedge radio_clk);
   endtask

   task automatic test_misc_loop();
      logic [31:0] mo;
      logic [63:0] rd;
      mo = $random(seed);
      write_reg(sr_db_base_default + sr_misc_out, mo);
      check_eq(misc_out, 0, "misc out one cycle after write");
      @(negedge radio_clk);
      check_eq(misc_out, mo, "misc out two cycles after write");
      misc_in = $random(seed);
      gpio_in = $random(seed);
      @(negedge radio_clk); // pins sampled once before readback
      read_reg(rb_gpio_misc, rd);
      check_eq(rd, {gpio_in, misc_in}, "gpio and misc readback");
   endtask

   task automatic test_rx_correction();
      logic [63:0] rd;
      swap_c[0] = 1'b0;
      dci_c[0]  = 16'sh7000;
      dcq_c[0]  = -16'sd300;
      swap_c[1] = 1'b1;
      dci_c[1]  = 16'sh9000;
      dcq_c[1]  = 16'sh0123;
      for (int c = 0; c < NCH; c++) begin
         write_reg(sr_rx_fe_base_default + 8'(c) * sr_fe_chan_offset + sr_fe_iq_swap,
                   {31'd0, swap_c[c]});
         write_reg(sr_rx_fe_base_default + 8'(c) * sr_fe_chan_offset + sr_fe_dc_offset,
                   {dci_c[c], dcq_c[c]});
      end
      read_reg(rb_fe, rd);
      check_eq(rd, {dci_c[1], dcq_c[1], dci_c[0], dcq_c[0]}, "dc offset readback");
      stream_samples(60, 2'b11);
      check_eq(stb_cnt[0], 60, "ch0 strobe count");
      check_eq(stb_cnt[1], 60, "ch1 strobe count");
   endtask

   task automatic test_gating_and_stray();
      logic [63:0] rd_pre  [3];
      logic [63:0] rd_post [3];
      logic [31:0] mo;
      logic [7:0]  a;
      int          n;
      stream_samples(40, 2'b01);
      check_eq(stb_cnt[1], 0, "stopped channel never strobes");
      check_eq(stb_cnt[0], 40, "running channel strobe count");
      read_reg(rb_gpio_misc, rd_pre[0]);
      read_reg(rb_atr, rd_pre[1]);
      read_reg(rb_fe, rd_pre[2]);
      mo = misc_out;
      n  = 0;
      while (n < 8) begin
         a = $random(seed);
         if (!in_blocks(a)) begin
            write_reg(a, $random(seed));
            n++;
         end
      end
      repeat (2) @(negedge radio_clk);
      read_reg(rb_gpio_misc, rd_post[0]);
      read_reg(rb_atr, rd_post[1]);
      read_reg(rb_fe, rd_post[2]);
      for (int r = 0; r < 3; r++) begin
         check_eq(rd_post[r], rd_pre[r], $sformatf("readback %0d after stray writes", r));
      end
      check_eq(misc_out, mo, "misc out after stray writes");
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      seed     = 32'h4615968e;
      rst_n    = 1'b0;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      rb_stb   = 1'b0;
      rb_addr  = rb_gpio_misc;
      rx_run   = '0;
      tx_run   = '0;
      rx       = '0;
      gpio_in  = '0;
      misc_in  = '0;
      repeat (8) @(negedge radio_clk);
      rst_n = 1'b1;
      test_reset_values();
      @(negedge radio_clk);
      test_atr_switching();
      test_misc_loop();
      test_rx_correction();
      test_gating_and_stray();
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
radio_regs_pkg.sv
radio_fe_pkg.sv
settings_regs.sv
db_atr_control.sv
rx_frontend.sv
radio_core_top.sv
tb_radio_core.sv

//--- Makefile
# Verilator flow for the radio slot: lint, simulate, clean

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_radio_core
RTL_TOP   ?= radio_core_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
